//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// cpu and memory word geometry
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	localparam int STRB_W = WORD_W / 8;

	// a line is 8 words of 32 bits
	localparam int LINE_WORDS = 8;
	localparam int LINE_W = LINE_WORDS * WORD_W;

	// address fields below the set index
	localparam int OFFSET_W = $clog2(LINE_W / 8);
	localparam int WORD_SEL_W = $clog2(LINE_WORDS);

	// fixed 4-way organisation, the PLRU tree only works for 4
	localparam int NUM_WAYS = 4;
	localparam int PLRU_W = NUM_WAYS - 1;

	// one-hot way vector
	typedef logic [NUM_WAYS-1:0] way_t;

	// controller states
	typedef enum logic [3:0] {
		IDLE,
		LOOKUP,
		EVICT,
		WB_REQ,
		WB_DATA,
		FILL_REQ,
		FILL_DATA,
		REFILL,
		WORD_READ,
		WORD_WRITE,
		RESP
	} cache_state_e;

endpackage

`default_nettype wire

//--- logic/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store import dcache_pkg::*; #(
	parameter int NUM_SETS = 8
) (
	input  wire logic                                       clk,
	input  wire logic                                       rst,
	input  wire logic [$clog2(NUM_SETS)-1:0]                set_idx,
	input  wire logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0] tag,
	input  wire way_t                                       sel_way,
	input  wire logic                                       refill,
	input  wire logic                                       word_write,
	input  wire logic                                       touch,
	output way_t                                            hit_way,
	output way_t                                            victim_way,
	output logic                                            victim_dirty,
	output logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0]      victim_tag
);

	localparam int SET_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

	// per set state bits, one bit per way
	logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
	logic [PLRU_W-1:0]   plru_q  [NUM_SETS];
	// tags need no reset, valid masks them
	logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];

	// state of the addressed set
	logic [NUM_WAYS-1:0] set_valid;
	logic [NUM_WAYS-1:0] set_dirty;
	logic [PLRU_W-1:0]   set_plru;

	assign set_valid = valid_q[set_idx];
	assign set_dirty = dirty_q[set_idx];
	assign set_plru  = plru_q[set_idx];

	// all four tags compared in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = set_valid[w] && (tag_q[set_idx][w] == tag);
		end
	end

	// invalid ways first in order 0..3, else walk the tree
	always_comb begin
		if (!set_valid[0])
			victim_way = 4'b0001;
		else if (!set_valid[1])
			victim_way = 4'b0010;
		else if (!set_valid[2])
			victim_way = 4'b0100;
		else if (!set_valid[3])
			victim_way = 4'b1000;
		else if (!set_plru[0])
			// pair 0/1, bit1 picks way1
			victim_way = set_plru[1] ? 4'b0010 : 4'b0001;
		else
			// pair 2/3, bit2 picks way3
			victim_way = set_plru[2] ? 4'b1000 : 4'b0100;
	end

	assign victim_dirty = |(victim_way & set_dirty & set_valid);

	// tag of the victim, used for the write-back address
	always_comb begin
		victim_tag = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (victim_way[w])
				victim_tag = tag_q[set_idx][w];
		end
	end

	// valid, dirty and plru updates
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				plru_q[s]  <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (sel_way[w] && refill) begin
					valid_q[set_idx][w] <= 1'b1;
					dirty_q[set_idx][w] <= 1'b0;
				end else if (sel_way[w] && word_write) begin
					dirty_q[set_idx][w] <= 1'b1;
				end
			end
			// point the tree away from the way just used
			if (touch) begin
				plru_q[set_idx][0] <= sel_way[0] | sel_way[1];
				if (sel_way[0] | sel_way[1])
					plru_q[set_idx][1] <= sel_way[0];
				else
					plru_q[set_idx][2] <= sel_way[2];
			end
		end
	end

	// new tag written with the line
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sel_way[w] && refill)
				tag_q[set_idx][w] <= tag;
		end
	end

	// a tag lives in at most one way of a set
	a_hit_onehot0: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hit_way));

	// controller must have picked exactly one way before any update
	a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		(refill || word_write || touch) |-> $onehot(sel_way));

endmodule

`default_nettype wire

//--- logic/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store import dcache_pkg::*; #(
	parameter int NUM_SETS = 8
) (
	input  wire logic                        clk,
	input  wire logic [$clog2(NUM_SETS)-1:0] set_idx,
	input  wire logic [WORD_SEL_W-1:0]       word_sel,
	input  wire way_t                        sel_way,
	input  wire logic                        refill,
	input  wire logic [LINE_W-1:0]           refill_line,
	input  wire logic                        word_write,
	input  wire logic [WORD_W-1:0]           wdata,
	input  wire logic [STRB_W-1:0]           wstrb,
	output logic [LINE_W-1:0]                line_out,
	output logic [WORD_W-1:0]                word_out
);

	// one line per way per set
	logic [LINE_W-1:0] lines_q [NUM_WAYS][NUM_SETS];

	// combinational read, selected way only
	always_comb begin
		line_out = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sel_way[w])
				line_out = lines_q[w][set_idx];
		end
	end

	// word within the line
	assign word_out = line_out[word_sel*WORD_W +: WORD_W];

	// whole line on refill, strobed bytes on a cpu write
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sel_way[w]) begin
				if (refill) begin
					lines_q[w][set_idx] <= refill_line;
				end else if (word_write) begin
					for (int b = 0; b < STRB_W; b++) begin
						// untouched bytes keep their old value
						if (wstrb[b])
							lines_q[w][set_idx][word_sel*WORD_W + b*8 +: 8] <= wdata[b*8 +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/dcache_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_line_buffer import dcache_pkg::*; (
	input  wire logic              clk,
	input  wire logic              load,
	input  wire logic [LINE_W-1:0] load_line,
	input  wire logic              fill_beat,
	input  wire logic [WORD_W-1:0] fill_data,
	input  wire logic              wb_advance,
	output logic [LINE_W-1:0]      line,
	output logic [WORD_W-1:0]      wb_beat,
	output logic                   wb_last
);

	// shift register shared by fill and write-back
	logic [LINE_W-1:0] line_q;
	// write-back beat count, restarted by every load
	logic [WORD_SEL_W-1:0] beat_cnt;

	always_ff @(posedge clk) begin
		if (load)
			// victim line from the data store
			line_q <= load_line;
		else if (fill_beat)
			// new beat enters at the top and walks down
			line_q <= {fill_data, line_q[LINE_W-1:WORD_W]};
		else if (wb_advance)
			// next word drops into the bottom slot
			line_q <= {{WORD_W{1'b0}}, line_q[LINE_W-1:WORD_W]};
	end

	always_ff @(posedge clk) begin
		if (load)
			beat_cnt <= '0;
		else if (wb_advance)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// after 8 fill beats word 0 sits at the bottom
	assign line = line_q;

	// the bottom word is always the beat on the bus
	assign wb_beat = line_q[WORD_W-1:0];

	// eighth beat of the write burst
	assign wb_last = (beat_cnt == WORD_SEL_W'(LINE_WORDS - 1));

	// fill and write-back never overlap in the controller
	a_no_fill_and_wb: assert property (@(posedge clk)
		!(fill_beat && wb_advance));

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
	parameter int NUM_SETS = 8
) (
	input  wire logic                                        clk,
	input  wire logic                                        rst,
	// cpu request and response
	input  wire logic                                        req_valid,
	input  wire logic                                        req_write,
	input  wire logic [ADDR_W-1:0]                           req_addr,
	input  wire logic [WORD_W-1:0]                           req_wdata,
	input  wire logic [STRB_W-1:0]                           req_wstrb,
	output logic                                             req_ready,
	output logic                                             rsp_valid,
	output logic [WORD_W-1:0]                                rsp_data,
	input  wire logic                                        rsp_ready,
	// memory read port
	output logic                                             rd_req_valid,
	output logic [ADDR_W-1:0]                                rd_req_addr,
	input  wire logic                                        rd_req_ready,
	input  wire logic                                        rd_rsp_valid,
	input  wire logic                                        rd_rsp_last,
	output logic                                             rd_rsp_ready,
	// memory write port
	output logic                                             wr_req_valid,
	output logic [ADDR_W-1:0]                                wr_req_addr,
	input  wire logic                                        wr_req_ready,
	output logic                                             wr_data_valid,
	output logic [WORD_W-1:0]                                wr_data,
	output logic                                             wr_data_last,
	input  wire logic                                        wr_data_ready,
	// results from the stores and the buffer
	input  wire way_t                                        hit_way,
	input  wire way_t                                        victim_way,
	input  wire logic                                        victim_dirty,
	input  wire logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0] victim_tag,
	input  wire logic [WORD_W-1:0]                           word_out,
	input  wire logic [LINE_W-1:0]                           fill_line,
	input  wire logic [WORD_W-1:0]                           wb_beat,
	input  wire logic                                        wb_last,
	// controls to the stores and the buffer
	output logic [$clog2(NUM_SETS)-1:0]                      set_idx,
	output logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0]      tag,
	output logic [WORD_SEL_W-1:0]                            word_sel,
	output way_t                                             sel_way,
	output logic                                             refill,
	output logic                                             word_write,
	output logic                                             touch,
	output logic [WORD_W-1:0]                                wdata,
	output logic [STRB_W-1:0]                                wstrb,
	output logic                                             load,
	output logic                                             fill_beat,
	output logic                                             wb_advance
);

	localparam int SET_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

	cache_state_e state, state_next;

	// latched request
	logic              req_write_q;
	logic [ADDR_W-1:0] req_addr_q;
	logic [WORD_W-1:0] req_wdata_q;
	logic [STRB_W-1:0] req_wstrb_q;
	// write-back line address, fixed when the victim is chosen
	logic [ADDR_W-1:0] wb_addr_q;

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE:       if (req_valid) state_next = LOOKUP;
			LOOKUP: begin
				if (|hit_way)
					state_next = req_write_q ? WORD_WRITE : WORD_READ;
				else
					state_next = EVICT;
			end
			// clean victims skip the write burst
			EVICT:      state_next = victim_dirty ? WB_REQ : FILL_REQ;
			WB_REQ:     if (wr_req_ready) state_next = WB_DATA;
			WB_DATA:    if (wr_data_ready && wb_last) state_next = FILL_REQ;
			FILL_REQ:   if (rd_req_ready) state_next = FILL_DATA;
			FILL_DATA:  if (rd_rsp_valid && rd_rsp_last) state_next = REFILL;
			REFILL:     state_next = req_write_q ? WORD_WRITE : WORD_READ;
			WORD_READ:  state_next = RESP;
			WORD_WRITE: state_next = IDLE;
			RESP:       if (rsp_ready) state_next = IDLE;
			default:    state_next = IDLE;
		endcase
	end

	// request captured on the accepting edge
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			req_write_q <= req_write;
			req_addr_q  <= req_addr;
			req_wdata_q <= req_wdata;
			req_wstrb_q <= req_wstrb;
		end
	end

	// hit way on lookup, victim way on a miss
	always_ff @(posedge clk) begin
		if (rst)
			sel_way <= '0;
		else if (state == LOOKUP && |hit_way)
			sel_way <= hit_way;
		else if (state == EVICT)
			sel_way <= victim_way;
	end

	always_ff @(posedge clk) begin
		if (state == EVICT)
			wb_addr_q <= {victim_tag, set_idx, {OFFSET_W{1'b0}}};
	end

	// read word held through the response
	always_ff @(posedge clk) begin
		if (state == WORD_READ)
			rsp_data <= word_out;
	end

	// address fields of the latched request
	assign tag      = req_addr_q[ADDR_W-1 -: TAG_W];
	assign set_idx  = req_addr_q[OFFSET_W +: SET_W];
	assign word_sel = req_addr_q[OFFSET_W-1 -: WORD_SEL_W];
	assign wdata    = req_wdata_q;
	assign wstrb    = req_wstrb_q;

	// store and buffer strobes
	assign refill     = (state == REFILL);
	assign word_write = (state == WORD_WRITE);
	assign touch      = (state == WORD_READ) || (state == WORD_WRITE);
	assign load       = (state == WB_REQ);
	assign fill_beat  = (state == FILL_DATA) && rd_rsp_valid;
	assign wb_advance = (state == WB_DATA) && wr_data_ready;

	// cpu side
	assign req_ready = (state == IDLE);
	assign rsp_valid = (state == RESP);

	// memory side, always whole aligned lines
	assign rd_req_valid  = (state == FILL_REQ);
	assign rd_req_addr   = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign rd_rsp_ready  = (state == FILL_DATA);
	assign wr_req_valid  = (state == WB_REQ);
	assign wr_req_addr   = wb_addr_q;
	assign wr_data_valid = (state == WB_DATA);
	assign wr_data       = wb_beat;
	assign wr_data_last  = (state == WB_DATA) && wb_last;

	// response held stable while the cpu stalls
	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data) && !req_ready));

	// data store holds the buffered fill line after a refill
	a_refill_word: assert property (@(posedge clk) disable iff (rst)
		(state == REFILL) |=> (word_out == fill_line[word_sel*WORD_W +: WORD_W]));

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
	parameter int NUM_SETS = 8
) (
	input  wire logic              clk,
	input  wire logic              rst,
	// cpu request
	input  wire logic              req_valid,
	input  wire logic              req_write,
	input  wire logic [ADDR_W-1:0] req_addr,
	input  wire logic [WORD_W-1:0] req_wdata,
	input  wire logic [STRB_W-1:0] req_wstrb,
	output logic                   req_ready,
	// cpu response, reads only
	output logic                   rsp_valid,
	output logic [WORD_W-1:0]      rsp_data,
	input  wire logic              rsp_ready,
	// memory read burst
	output logic                   rd_req_valid,
	output logic [ADDR_W-1:0]      rd_req_addr,
	input  wire logic              rd_req_ready,
	input  wire logic              rd_rsp_valid,
	input  wire logic [WORD_W-1:0] rd_rsp_data,
	input  wire logic              rd_rsp_last,
	output logic                   rd_rsp_ready,
	// memory write burst
	output logic                   wr_req_valid,
	output logic [ADDR_W-1:0]      wr_req_addr,
	input  wire logic              wr_req_ready,
	output logic                   wr_data_valid,
	output logic [WORD_W-1:0]      wr_data,
	output logic                   wr_data_last,
	input  wire logic              wr_data_ready
);

	localparam int SET_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

	// controller to stores and buffer
	logic [SET_W-1:0]      set_idx;
	logic [TAG_W-1:0]      tag;
	logic [WORD_SEL_W-1:0] word_sel;
	way_t                  sel_way;
	logic                  refill;
	logic                  word_write;
	logic                  touch;
	logic [WORD_W-1:0]     wdata;
	logic [STRB_W-1:0]     wstrb;
	logic                  load;
	logic                  fill_beat;
	logic                  wb_advance;

	// tag store results
	way_t                  hit_way;
	way_t                  victim_way;
	logic                  victim_dirty;
	logic [TAG_W-1:0]      victim_tag;

	// data path
	logic [LINE_W-1:0]     line_out;
	logic [WORD_W-1:0]     word_out;
	logic [LINE_W-1:0]     fill_line;
	logic [WORD_W-1:0]     wb_beat;
	logic                  wb_last;

	dcache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
		.clk, .rst,
		.req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb, .req_ready,
		.rsp_valid, .rsp_data, .rsp_ready,
		.rd_req_valid, .rd_req_addr, .rd_req_ready,
		.rd_rsp_valid, .rd_rsp_last, .rd_rsp_ready,
		.wr_req_valid, .wr_req_addr, .wr_req_ready,
		.wr_data_valid, .wr_data, .wr_data_last, .wr_data_ready,
		.hit_way, .victim_way, .victim_dirty, .victim_tag,
		.word_out, .fill_line, .wb_beat, .wb_last,
		.set_idx, .tag, .word_sel, .sel_way,
		.refill, .word_write, .touch, .wdata, .wstrb,
		.load, .fill_beat, .wb_advance
	);

	dcache_tag_store #(.NUM_SETS(NUM_SETS)) u_tag_store (
		.clk, .rst,
		.set_idx, .tag, .sel_way,
		.refill, .word_write, .touch,
		.hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	// refill line comes straight from the buffer
	dcache_data_store #(.NUM_SETS(NUM_SETS)) u_data_store (
		.clk,
		.set_idx, .word_sel, .sel_way,
		.refill, .refill_line(fill_line),
		.word_write, .wdata, .wstrb,
		.line_out, .word_out
	);

	// victim line loaded from the selected way
	dcache_line_buffer u_line_buffer (
		.clk,
		.load, .load_line(line_out),
		.fill_beat, .fill_data(rd_rsp_data),
		.wb_advance,
		.line(fill_line), .wb_beat, .wb_last
	);

endmodule

`default_nettype wire

//--- include/tb_dcache_tasks.svh
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

// address layout for the default geometry
localparam int OFFSET_BITS = 5;
localparam int SET_BITS = $clog2(NUM_SETS);

// word value memory returns before anything was written there
function automatic logic [31:0] untouched_word(input logic [31:0] addr);
	return {addr[31:2], 2'b00} ^ 32'hA5A5A5A5;
endfunction

// strobed bytes from new, the rest from old
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
	logic [31:0] res;
	res = old_word;
	for (int b = 0; b < 4; b++) begin
		if (strb[b])
			res[b*8 +: 8] = new_word[b*8 +: 8];
	end
	return res;
endfunction

function automatic logic [31:0] line_base(input logic [31:0] addr);
	return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
endfunction

// tags 0x100+n, all mapped onto set 3
function automatic logic [31:0] tag_addr(input int n, input logic [4:0] offset);
	return ((32'h100 + n) << (OFFSET_BITS + SET_BITS)) | (3 << OFFSET_BITS) | offset;
endfunction

task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
	checks++;
	assert (got === exp) else begin
		errors++;
		$display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
	end
endtask

// lat counts falling edges from acceptance to the first rsp_valid
task automatic read_word(input logic [31:0] addr, output logic [31:0] data, output int lat);
	@(negedge clk);
	req_valid = 1'b1;
	req_write = 1'b0;
	req_addr  = addr;
	req_wdata = '0;
	req_wstrb = '0;
	while (!req_ready)
		@(negedge clk);
	@(negedge clk);
	req_valid = 1'b0;
	lat = 1;
	while (!rsp_valid) begin
		@(negedge clk);
		lat++;
	end
	data = rsp_data;
	// response taken on the next rising edge
	if (rsp_ready)
		@(negedge clk);
endtask

// lat counts falling edges from acceptance until req_ready is back
task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb, output int lat);
	@(negedge clk);
	req_valid = 1'b1;
	req_write = 1'b1;
	req_addr  = addr;
	req_wdata = wdata;
	req_wstrb = strb;
	while (!req_ready)
		@(negedge clk);
	@(negedge clk);
	req_valid = 1'b0;
	req_write = 1'b0;
	lat = 1;
	while (!req_ready) begin
		@(negedge clk);
		lat++;
	end
endtask

// one access plus its memory traffic, a hit must take 3 cycles
task automatic checked_access(input bit write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb, input logic [31:0] exp_rdata,
		input int exp_fills, input int exp_wbs, input string what);
	int          rd0;
	int          wr0;
	int          lat;
	logic [31:0] data;
	rd0 = rd_bursts;
	wr0 = wr_bursts;
	if (write) begin
		write_word(addr, wdata, strb, lat);
	end else begin
		read_word(addr, data, lat);
		expect_eq(data, exp_rdata, {what, ": read data"});
	end
	expect_eq(rd_bursts - rd0, exp_fills, {what, ": read bursts"});
	expect_eq(wr_bursts - wr0, exp_wbs, {what, ": write bursts"});
	if (exp_fills > 0)
		expect_eq(last_rd_addr, line_base(addr), {what, ": fill address"});
	else
		expect_eq(lat, 3, {what, ": hit latency"});
endtask

task automatic reset_and_miss();
	expect_eq(req_ready, 1'b1, "req_ready after reset");
	expect_eq(rsp_valid, 1'b0, "rsp_valid after reset");
	expect_eq(rd_req_valid, 1'b0, "rd_req_valid after reset");
	expect_eq(rd_rsp_ready, 1'b0, "rd_rsp_ready after reset");
	expect_eq(wr_req_valid, 1'b0, "wr_req_valid after reset");
	expect_eq(wr_data_valid, 1'b0, "wr_data_valid after reset");
	expect_eq(wr_data_last, 1'b0, "wr_data_last after reset");
	checked_access(0, 32'h1044, 0, 0, untouched_word(32'h1044), 1, 0, "cold read miss");
endtask

task automatic read_hit();
	checked_access(0, 32'h1044, 0, 0, untouched_word(32'h1044), 0, 0, "read hit same word");
	checked_access(0, 32'h105C, 0, 0, untouched_word(32'h105C), 0, 0, "read hit last word");
endtask

task automatic write_hit_merge();
	logic [31:0] merged;
	merged = merge_bytes(untouched_word(32'h1048), 32'hDEADBEEF, 4'b0101);
	checked_access(1, 32'h1048, 32'hDEADBEEF, 4'b0101, 0, 0, 0, "partial write hit");
	checked_access(0, 32'h1048, 0, 0, merged, 0, 0, "read after write");
endtask

task automatic plru_eviction();
	logic [31:0] dirty_addr;
	logic [31:0] new_word;
	logic [31:0] exp_beat;
	// empty set, ways 0..3 take tags 0..3, tree ends at 000
	for (int i = 0; i < 4; i++) begin
		checked_access(0, tag_addr(i, 0), 0, 0, untouched_word(tag_addr(i, 0)), 1, 0,
			$sformatf("fill tag %0d", i));
	end
	dirty_addr = tag_addr(1, 5'h0C);
	new_word = merge_bytes(untouched_word(dirty_addr), 32'h12345678, 4'b1100);
	// way1 dirty, tree 1,0,0
	checked_access(1, dirty_addr, 32'h12345678, 4'b1100, 0, 0, 0, "dirty write tag 1");
	// way2 gives 0,0,1 then way0 gives 1,1,1 then way3 gives 0,1,0
	checked_access(0, tag_addr(2, 0), 0, 0, untouched_word(tag_addr(2, 0)), 0, 0, "touch tag 2");
	checked_access(0, tag_addr(0, 0), 0, 0, untouched_word(tag_addr(0, 0)), 0, 0, "touch tag 0");
	checked_access(0, tag_addr(3, 0), 0, 0, untouched_word(tag_addr(3, 0)), 0, 0, "touch tag 3");
	// pair 0/1 with bit1 set, so way1 and its dirty line go out
	checked_access(0, tag_addr(4, 0), 0, 0, untouched_word(tag_addr(4, 0)), 1, 1, "evict tag 1");
	expect_eq(last_wr_addr, tag_addr(1, 0), "write-back address");
	for (int i = 0; i < 8; i++) begin
		exp_beat = (i == 3) ? new_word : untouched_word(tag_addr(1, 5'(4 * i)));
		expect_eq(wb_line[i], exp_beat, $sformatf("write-back beat %0d", i));
	end
	// tree 1,0,0 points at way2, clean
	checked_access(0, tag_addr(5, 0), 0, 0, untouched_word(tag_addr(5, 0)), 1, 0, "evict tag 2");
	checked_access(0, tag_addr(0, 0), 0, 0, untouched_word(tag_addr(0, 0)), 0, 0, "tag 0 kept");
	// tag 2 now misses and pushes out clean way3
	checked_access(0, tag_addr(2, 0), 0, 0, untouched_word(tag_addr(2, 0)), 1, 0, "tag 2 gone");
	// tag 1 comes back from memory with the written bytes, way1 is clean
	checked_access(0, dirty_addr, 0, 0, new_word, 1, 0, "refetch tag 1");
endtask

task automatic response_backpressure();
	logic [31:0] data;
	int          lat;
	int          rd0;
	rd0 = rd_bursts;
	@(negedge clk);
	rsp_ready = 1'b0;
	read_word(32'h104C, data, lat);
	expect_eq(data, untouched_word(32'h104C), "stalled read data");
	expect_eq(lat, 3, "stalled read latency");
	// response must sit still while the cpu stalls
	repeat (5) begin
		@(negedge clk);
		expect_eq(rsp_valid, 1'b1, "rsp_valid held");
		expect_eq(rsp_data, data, "rsp_data held");
		expect_eq(req_ready, 1'b0, "req_ready low during stall");
	end
	rsp_ready = 1'b1;
	@(negedge clk);
	expect_eq(rsp_valid, 1'b0, "rsp_valid after release");
	expect_eq(req_ready, 1'b1, "req_ready after release");
	expect_eq(rd_bursts - rd0, 0, "no fill for stalled hit");
endtask

`endif

//--- test/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam int NUM_SETS = 8;
	localparam int NUM_TESTS = 5;
	// upper bound on cpu accesses in any single test
	localparam int ACCESSES_PER_TEST = 16;
	// write-back plus refill with the slowest memory answers, plus fsm overhead
	localparam int WORST_MISS_CYCLES = 48;
	localparam int TIMEOUT_CYCLES = 10 + NUM_TESTS * ACCESSES_PER_TEST * WORST_MISS_CYCLES;

	logic        clk;
	logic        rst;
	logic        req_valid;
	logic        req_write;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic [3:0]  req_wstrb;
	logic        req_ready;
	logic        rsp_valid;
	logic [31:0] rsp_data;
	logic        rsp_ready;
	logic        rd_req_valid;
	logic [31:0] rd_req_addr;
	logic        rd_req_ready;
	logic        rd_rsp_valid;
	logic [31:0] rd_rsp_data;
	logic        rd_rsp_last;
	logic        rd_rsp_ready;
	logic        wr_req_valid;
	logic [31:0] wr_req_addr;
	logic        wr_req_ready;
	logic        wr_data_valid;
	logic [31:0] wr_data;
	logic        wr_data_last;
	logic        wr_data_ready;

	// sparse memory behind the cache, keyed by word-aligned byte address
	logic [31:0] mem [logic [31:0]];
	int          rd_bursts;
	int          wr_bursts;
	logic [31:0] last_rd_addr;
	logic [31:0] last_wr_addr;
	// beats of the most recent write burst
	logic [31:0] wb_line [8];

	int     checks;
	int     errors;
	int     cycle_cnt;
	integer seed = 15;

	`include "tb_dcache_tasks.svh"

	dcache_top #(.NUM_SETS(NUM_SETS)) i_dut (
		.clk, .rst,
		.req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb, .req_ready,
		.rsp_valid, .rsp_data, .rsp_ready,
		.rd_req_valid, .rd_req_addr, .rd_req_ready,
		.rd_rsp_valid, .rd_rsp_data, .rd_rsp_last, .rd_rsp_ready,
		.wr_req_valid, .wr_req_addr, .wr_req_ready,
		.wr_data_valid, .wr_data, .wr_data_last, .wr_data_ready
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory answer delay, 0..max_cycles falling edges
	task automatic random_wait(input int max_cycles);
		int n;
		n = $unsigned($random(seed)) % (max_cycles + 1);
		repeat (n) @(negedge clk);
	endtask

	// never-written words read as address xor a fixed pattern
	function automatic logic [31:0] memory_word(input logic [31:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'hA5A5A5A5;
	endfunction

	// read port model, one 8-beat burst per request
	initial begin
		rd_req_ready = 1'b0;
		rd_rsp_valid = 1'b0;
		rd_rsp_data  = '0;
		rd_rsp_last  = 1'b0;
		rd_bursts    = 0;
		forever begin
			@(negedge clk);
			if (!rst && rd_req_valid) begin
				random_wait(3);
				rd_req_ready = 1'b1;
				last_rd_addr = rd_req_addr;
				rd_bursts++;
				@(negedge clk);
				rd_req_ready = 1'b0;
				for (int i = 0; i < 8; i++) begin
					// drop valid during a gap so no beat is taken twice
					rd_rsp_valid = 1'b0;
					random_wait(1);
					rd_rsp_valid = 1'b1;
					rd_rsp_data  = memory_word(last_rd_addr + 4 * i);
					rd_rsp_last  = (i == 7);
					while (!rd_rsp_ready)
						@(negedge clk);
					@(negedge clk);
				end
				rd_rsp_valid = 1'b0;
				rd_rsp_last  = 1'b0;
			end
		end
	end

	// write port model, stores every beat it takes
	initial begin
		wr_req_ready  = 1'b0;
		wr_data_ready = 1'b0;
		wr_bursts     = 0;
		forever begin
			@(negedge clk);
			if (!rst && wr_req_valid) begin
				random_wait(3);
				wr_req_ready = 1'b1;
				last_wr_addr = wr_req_addr;
				wr_bursts++;
				@(negedge clk);
				wr_req_ready = 1'b0;
				for (int i = 0; i < 8; i++) begin
					wr_data_ready = 1'b0;
					random_wait(1);
					wr_data_ready = 1'b1;
					// beat is taken on the coming rising edge
					expect_eq(wr_data_valid, 1'b1, "write data valid in burst");
					expect_eq(wr_data_last, (i == 7), $sformatf("last flag on beat %0d", i));
					wb_line[i] = wr_data;
					mem[last_wr_addr + 4 * i] = wr_data;
					@(negedge clk);
				end
				wr_data_ready = 1'b0;
			end
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run not finished after %0d cycles, a handshake stalled",
				TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		checks    = 0;
		errors    = 0;
		cycle_cnt = 0;
		rst       = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		req_wstrb = '0;
		rsp_ready = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		reset_and_miss();
		read_hit();
		write_hit_merge();
		plru_eviction();
		response_backpressure();
		repeat (2) @(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_line_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
test/tb_dcache.sv
